/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int unsigned XLEN = 64;

    // datapath widths
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;
    // one-hot alu function, bit 14 spare
    typedef logic [14:0]     alu_sel_t;
    // [1] op1 signed, [0] op2 signed
    typedef logic [1:0]      sext_t;

    // alu_sel_t bit positions
    localparam int unsigned ALU_ADD  = 0;
    localparam int unsigned ALU_SUB  = 1;
    localparam int unsigned ALU_SLT  = 2;
    localparam int unsigned ALU_SLTU = 3;
    localparam int unsigned ALU_XOR  = 4;
    localparam int unsigned ALU_OR   = 5;
    localparam int unsigned ALU_AND  = 6;
    localparam int unsigned ALU_SLL  = 7;
    localparam int unsigned ALU_SRL  = 8;
    localparam int unsigned ALU_SRA  = 9;
    localparam int unsigned ALU_MUL  = 10;
    localparam int unsigned ALU_MULH = 11;
    localparam int unsigned ALU_DIV  = 12;
    localparam int unsigned ALU_REM  = 13;

    // major opcodes handled by this stage
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;

    typedef struct packed {
        alu_sel_t alu_sel;
        sext_t    sext;
        logic     word_op;
        logic     use_imm;
        logic     imm_s_fmt;
        logic     mem_access;
        logic     illegal;
        reg_idx_t rd;
    } alu_ctrl_t;

    typedef struct packed {
        xlen_t    result;
        xlen_t    mem_addr;
        reg_idx_t rd;
        logic     mem_access;
        logic     illegal;
    } exec_result_t;

endpackage

`default_nettype wire

/* verilog/exec_decoder.sv */
`default_nettype none

module exec_decoder (
    input  exec_pkg::instr_t    instr,
    output exec_pkg::alu_ctrl_t ctrl
);
    import exec_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    // index into the one-hot select
    int unsigned fn;
    logic        legal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        fn = ALU_ADD;
        legal = 1'b1;
        ctrl = '0;
        // signed unless the mnemonic says otherwise
        ctrl.sext = 2'b11;
        ctrl.rd = instr[11:7];
        case (opcode)
            ////////////////////////////////////////////////////////////////////////////
            // register forms, RV64I and M
            ////////////////////////////////////////////////////////////////////////////
            OPC_OP, OPC_OP_32: begin
                ctrl.word_op = (opcode == OPC_OP_32);
                case (funct7)
                    7'b0000000: begin
                        case (funct3)
                            3'b000: fn = ALU_ADD;
                            3'b001: fn = ALU_SLL;
                            3'b010: fn = ALU_SLT;
                            3'b011: fn = ALU_SLTU;
                            3'b100: fn = ALU_XOR;
                            3'b101: fn = ALU_SRL;
                            3'b110: fn = ALU_OR;
                            default: fn = ALU_AND;
                        endcase
                    end
                    7'b0100000: begin
                        if (funct3 == 3'b000) begin
                            fn = ALU_SUB;
                        end else if (funct3 == 3'b101) begin
                            fn = ALU_SRA;
                        end else begin
                            legal = 1'b0;
                        end
                    end
                    7'b0000001: begin
                        case (funct3)
                            3'b000: fn = ALU_MUL;
                            3'b001: fn = ALU_MULH;
                            // mulhsu, op2 unsigned
                            3'b010: begin
                                fn = ALU_MULH;
                                ctrl.sext = 2'b10;
                            end
                            3'b011: begin
                                fn = ALU_MULH;
                                ctrl.sext = 2'b00;
                            end
                            3'b100: fn = ALU_DIV;
                            3'b101: begin
                                fn = ALU_DIV;
                                ctrl.sext = 2'b00;
                            end
                            3'b110: fn = ALU_REM;
                            default: begin
                                fn = ALU_REM;
                                ctrl.sext = 2'b00;
                            end
                        endcase
                    end
                    default: legal = 1'b0;
                endcase
                // op-32 only defines a subset
                if (ctrl.word_op && funct7 != 7'b0000001 &&
                    !(funct3 inside {3'b000, 3'b001, 3'b101})) begin
                    legal = 1'b0;
                end
                if (ctrl.word_op && funct7 == 7'b0000001 &&
                    (funct3 inside {3'b001, 3'b010, 3'b011})) begin
                    legal = 1'b0;
                end
            end
            ////////////////////////////////////////////////////////////////////////////
            // immediate forms
            ////////////////////////////////////////////////////////////////////////////
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                ctrl.word_op = (opcode == OPC_OP_IMM_32);
                ctrl.use_imm = 1'b1;
                case (funct3)
                    3'b000: fn = ALU_ADD;
                    3'b010: fn = ALU_SLT;
                    3'b011: fn = ALU_SLTU;
                    3'b100: fn = ALU_XOR;
                    3'b110: fn = ALU_OR;
                    3'b111: fn = ALU_AND;
                    3'b001: begin
                        fn = ALU_SLL;
                        // shamt[5] reserved in word mode
                        legal = (instr[31:26] == 6'b0) && !(ctrl.word_op && instr[25]);
                    end
                    default: begin
                        fn = instr[30] ? ALU_SRA : ALU_SRL;
                        legal = !instr[31] && (instr[29:26] == 4'b0) &&
                                !(ctrl.word_op && instr[25]);
                    end
                endcase
                if (ctrl.word_op && !(funct3 inside {3'b000, 3'b001, 3'b101})) begin
                    legal = 1'b0;
                end
            end
            // address only, funct3 111 undefined
            OPC_LOAD: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_access = 1'b1;
                legal = (funct3 != 3'b111);
            end
            OPC_STORE: begin
                ctrl.use_imm = 1'b1;
                ctrl.imm_s_fmt = 1'b1;
                ctrl.mem_access = 1'b1;
                // no writeback
                ctrl.rd = '0;
                legal = !funct3[2];
            end
            default: legal = 1'b0;
        endcase
        ctrl.alu_sel = alu_sel_t'(1) << fn;
        // illegal collapses to a harmless add to x0
        if (!legal) begin
            ctrl = '0;
            ctrl.alu_sel[ALU_ADD] = 1'b1;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/operand_select.sv */
`default_nettype none

module operand_select (
    input  exec_pkg::instr_t    instr,
    input  exec_pkg::alu_ctrl_t ctrl,
    input  exec_pkg::xlen_t     rs2_val,
    output exec_pkg::xlen_t     op2
);
    import exec_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // immediate build
    ////////////////////////////////////////////////////////////////////////////

    logic [11:0] imm12;
    xlen_t       imm;

    // store splits the field around rd
    assign imm12 = ctrl.imm_s_fmt ? {instr[31:25], instr[11:7]} : instr[31:20];

    // sign bit always at instr[31]
    assign imm = {{(XLEN - 12){imm12[11]}}, imm12};

    ////////////////////////////////////////////////////////////////////////////
    // second operand
    ////////////////////////////////////////////////////////////////////////////

    // loads and stores take the immediate here too
    // so the alu adder forms the address
    assign op2 = ctrl.use_imm ? imm : rs2_val;

endmodule

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu (
    input  exec_pkg::xlen_t   op1,
    input  exec_pkg::xlen_t   op2,
    input  exec_pkg::alu_sel_t alu_sel,
    input  exec_pkg::sext_t   sext,
    input  logic              word_op,
    output exec_pkg::xlen_t   result,
    output exec_pkg::xlen_t   mem_addr
);
    import exec_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // adder, slt, sltu
    ////////////////////////////////////////////////////////////////////////////

    logic  sub_like;
    xlen_t adder_b;
    xlen_t sum;
    logic  cout;
    xlen_t slt_res;
    xlen_t sltu_res;

    assign sub_like = alu_sel[ALU_SUB] | alu_sel[ALU_SLT] | alu_sel[ALU_SLTU];
    // two's complement subtract via ~b + 1
    assign adder_b = sub_like ? ~op2 : op2;
    assign {cout, sum} = {1'b0, op1} + {1'b0, adder_b} + {{XLEN{1'b0}}, sub_like};

    // op1 neg and op2 pos, or same sign and negative diff
    assign slt_res = {{(XLEN - 1){1'b0}},
                      (op1[63] & ~op2[63]) | (~(op1[63] ^ op2[63]) & sum[63])};
    // borrow out means op1 < op2
    assign sltu_res = {{(XLEN - 1){1'b0}}, ~cout};

    ////////////////////////////////////////////////////////////////////////////
    // shifter, right only
    ////////////////////////////////////////////////////////////////////////////

    xlen_t       op1_rev;
    xlen_t       shift_in;
    logic [31:0] shift_in_w;
    xlen_t       srl_in;
    logic [5:0]  shamt;
    logic        shift_sign;
    xlen_t       sra_mask;
    xlen_t       shift_res;
    xlen_t       shift_rev;
    xlen_t       sll_res;
    xlen_t       sra_res;

    // left shift = reverse, shift right, reverse back
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            op1_rev[i] = op1[XLEN-1-i];
            shift_rev[i] = shift_res[XLEN-1-i];
        end
    end

    assign shift_in = alu_sel[ALU_SLL] ? op1_rev : op1;
    // reversed low word sits in the top half
    assign shift_in_w = alu_sel[ALU_SLL] ? shift_in[63:32] : shift_in[31:0];
    assign srl_in = word_op ? {32'b0, shift_in_w} : shift_in;
    assign shamt = word_op ? {1'b0, op2[4:0]} : op2[5:0];
    assign shift_res = srl_in >> shamt;

    // fill vacated high bits for sra
    assign shift_sign = word_op ? op1[31] : op1[63];
    assign sra_mask = word_op ? ~(64'h0000_0000_ffff_ffff >> shamt) : ~({XLEN{1'b1}} >> shamt);
    assign sra_res = ({XLEN{shift_sign}} & sra_mask) | shift_res;

    // upper word fixed up by final sign extension
    assign sll_res = word_op ? {32'b0, shift_rev[63:32]} : shift_rev;

    ////////////////////////////////////////////////////////////////////////////
    // multiply, divide, remainder
    ////////////////////////////////////////////////////////////////////////////

    logic               sign1;
    logic               sign2;
    logic signed [64:0] op1_x;
    logic signed [64:0] op2_x;
    logic signed [129:0] prod;
    logic signed [64:0] quot;
    logic signed [64:0] rmd;
    logic               div_zero;
    logic               div_ovf;
    logic               dividend_min;
    xlen_t              div_res;
    xlen_t              rem_res;

    // 65-bit extension covers signed and unsigned alike
    assign sign1 = sext[1] & (word_op ? op1[31] : op1[63]);
    assign sign2 = sext[0] & (word_op ? op2[31] : op2[63]);
    assign op1_x = word_op ? {{33{sign1}}, op1[31:0]} : {sign1, op1};
    assign op2_x = word_op ? {{33{sign2}}, op2[31:0]} : {sign2, op2};

    assign prod = op1_x * op2_x;
    assign quot = op1_x / op2_x;
    assign rmd  = op1_x % op2_x;

    // riscv special cases
    assign div_zero = (op2_x == '0);
    assign dividend_min = word_op ? (op1[31:0] == 32'h8000_0000) :
                                    (op1 == 64'h8000_0000_0000_0000);
    assign div_ovf = (&sext) & dividend_min & (op2_x == '1);

    assign div_res = div_zero ? {XLEN{1'b1}} : (div_ovf ? op1_x[63:0] : quot[63:0]);
    assign rem_res = div_zero ? op1_x[63:0] : (div_ovf ? '0 : rmd[63:0]);

    ////////////////////////////////////////////////////////////////////////////
    // result mux
    ////////////////////////////////////////////////////////////////////////////

    xlen_t dword_res;

    assign dword_res = ({XLEN{alu_sel[ALU_ADD] | alu_sel[ALU_SUB]}} & sum)
                     | ({XLEN{alu_sel[ALU_SLT]}}  & slt_res)
                     | ({XLEN{alu_sel[ALU_SLTU]}} & sltu_res)
                     | ({XLEN{alu_sel[ALU_XOR]}}  & (op1 ^ op2))
                     | ({XLEN{alu_sel[ALU_OR]}}   & (op1 | op2))
                     | ({XLEN{alu_sel[ALU_AND]}}  & (op1 & op2))
                     | ({XLEN{alu_sel[ALU_SLL]}}  & sll_res)
                     | ({XLEN{alu_sel[ALU_SRL]}}  & shift_res)
                     | ({XLEN{alu_sel[ALU_SRA]}}  & sra_res)
                     | ({XLEN{alu_sel[ALU_MUL]}}  & prod[63:0])
                     | ({XLEN{alu_sel[ALU_MULH]}} & prod[127:64])
                     | ({XLEN{alu_sel[ALU_DIV]}}  & div_res)
                     | ({XLEN{alu_sel[ALU_REM]}}  & rem_res);

    // w forms, divuw/remuw included, extend bit 31
    assign result = word_op ? {{32{dword_res[31]}}, dword_res[31:0]} : dword_res;

    assign mem_addr = sum;

endmodule

`default_nettype wire

/* verilog/exec_result_reg.sv */
`default_nettype none

module exec_result_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  exec_pkg::alu_ctrl_t    ctrl,
    input  exec_pkg::xlen_t        result,
    input  exec_pkg::xlen_t        mem_addr,
    output logic                   out_valid,
    output exec_pkg::exec_result_t out_result
);
    import exec_pkg::*;

    exec_result_t next_result;

    // x0 and illegal encodings write nothing
    always_comb begin
        next_result.result = (ctrl.rd == '0 || ctrl.illegal) ? '0 : result;
        next_result.mem_addr = mem_addr;
        next_result.rd = ctrl.rd;
        next_result.mem_access = ctrl.mem_access;
        next_result.illegal = ctrl.illegal;
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_result <= '0;
        end else begin
            // one-cycle strobe follows input
            out_valid <= in_valid;
            // hold last result when idle
            if (in_valid) begin
                out_result <= next_result;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_stage.sv */
`default_nettype none

module exec_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  exec_pkg::instr_t       instr,
    input  exec_pkg::xlen_t        rs1_val,
    input  exec_pkg::xlen_t        rs2_val,
    output logic                   out_valid,
    output exec_pkg::exec_result_t out_result
);
    import exec_pkg::*;

    alu_ctrl_t ctrl;
    xlen_t     op2;
    xlen_t     alu_result;
    xlen_t     mem_addr;

    // decode
    exec_decoder exec_decoder_i (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // immediate or rs2
    operand_select operand_select_i (
        .instr   (instr),
        .ctrl    (ctrl),
        .rs2_val (rs2_val),
        .op2     (op2)
    );

    alu alu_i (
        .op1      (rs1_val),
        .op2      (op2),
        .alu_sel  (ctrl.alu_sel),
        .sext     (ctrl.sext),
        .word_op  (ctrl.word_op),
        .result   (alu_result),
        .mem_addr (mem_addr)
    );

    // one cycle to the output
    exec_result_reg exec_result_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .ctrl       (ctrl),
        .result     (alu_result),
        .mem_addr   (mem_addr),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

/* verification/exec_stage_vectors.svh */
task automatic load_vectors();
    // alu_row:  funct7, funct3, opcode, rs1, rs2, expected result (rd = x10)
    // imm_row:  imm12, funct3, opcode, rs1, expected result (rd = x10)
    // mem_row:  instruction, rs1, expected address, expected rd

    ////////////////////////////////////////////////////////////////////////////
    // rv64i register forms
    ////////////////////////////////////////////////////////////////////////////
    alu_row(7'h00, 3'h0, ENC_R, 64'h5, 64'h7, 64'hc);
    alu_row(7'h00, 3'h0, ENC_R, 64'hffff_ffff_ffff_ffff, 64'h1, 64'h0);
    alu_row(7'h20, 3'h0, ENC_R, 64'h5, 64'h7, 64'hffff_ffff_ffff_fffe);
    // slt and sltu across sign boundaries
    alu_row(7'h00, 3'h2, ENC_R, 64'hffff_ffff_ffff_ffff, 64'h1, 64'h1);
    alu_row(7'h00, 3'h2, ENC_R, 64'h1, 64'hffff_ffff_ffff_ffff, 64'h0);
    alu_row(7'h00, 3'h2, ENC_R, 64'hffff_ffff_ffff_fffb, 64'hffff_ffff_ffff_fffd, 64'h1);
    alu_row(7'h00, 3'h3, ENC_R, 64'hffff_ffff_ffff_ffff, 64'h1, 64'h0);
    alu_row(7'h00, 3'h3, ENC_R, 64'h1, 64'hffff_ffff_ffff_ffff, 64'h1);
    alu_row(7'h00, 3'h4, ENC_R, 64'hff00_ff00_ff00_ff00, 64'h0f0f_0f0f_0f0f_0f0f,
            64'hf00f_f00f_f00f_f00f);
    alu_row(7'h00, 3'h6, ENC_R, 64'hff00_ff00_ff00_ff00, 64'h0f0f_0f0f_0f0f_0f0f,
            64'hff0f_ff0f_ff0f_ff0f);
    alu_row(7'h00, 3'h7, ENC_R, 64'hff00_ff00_ff00_ff00, 64'h0f0f_0f0f_0f0f_0f0f,
            64'h0f00_0f00_0f00_0f00);
    // shift amount 63, and 0 with rs2 bit 6 set
    alu_row(7'h00, 3'h1, ENC_R, 64'h1, 64'h3f, 64'h8000_0000_0000_0000);
    alu_row(7'h00, 3'h1, ENC_R, 64'h1234_5678_9abc_def0, 64'h40, 64'h1234_5678_9abc_def0);
    alu_row(7'h00, 3'h5, ENC_R, 64'h8000_0000_0000_0000, 64'h3f, 64'h1);
    alu_row(7'h20, 3'h5, ENC_R, 64'h8000_0000_0000_0000, 64'h3f, 64'hffff_ffff_ffff_ffff);
    alu_row(7'h20, 3'h5, ENC_R, 64'hf000_0000_0000_0010, 64'h4, 64'hff00_0000_0000_0001);

    // immediate forms
    imm_row(12'hfff, 3'h0, ENC_I, 64'h10, 64'hf);
    imm_row(12'h000, 3'h2, ENC_I, 64'hffff_ffff_ffff_ffff, 64'h1);
    imm_row(12'hfff, 3'h3, ENC_I, 64'h5, 64'h1);
    imm_row(12'hfff, 3'h4, ENC_I, 64'hff, 64'hffff_ffff_ffff_ff00);
    imm_row(12'h0f0, 3'h6, ENC_I, 64'hf, 64'hff);
    imm_row(12'h0f0, 3'h7, ENC_I, 64'hffff_ffff_ffff_ffff, 64'hf0);
    imm_row(12'h03f, 3'h1, ENC_I, 64'h3, 64'h8000_0000_0000_0000);
    imm_row(12'h000, 3'h5, ENC_I, 64'hdead_beef_0000_0001, 64'hdead_beef_0000_0001);
    imm_row(12'h03f, 3'h5, ENC_I, 64'h8000_0000_0000_0000, 64'h1);
    imm_row(12'h408, 3'h5, ENC_I, 64'h8000_0000_0000_0000, 64'hff80_0000_0000_0000);

    ////////////////////////////////////////////////////////////////////////////
    // word forms, bit 31 extended, shamt bit 5 ignored
    ////////////////////////////////////////////////////////////////////////////
    alu_row(7'h00, 3'h0, ENC_RW, 64'h7fff_ffff, 64'h1, 64'hffff_ffff_8000_0000);
    alu_row(7'h00, 3'h0, ENC_RW, 64'hffff_ffff_0000_0001, 64'h1234_5678_0000_0002, 64'h3);
    alu_row(7'h20, 3'h0, ENC_RW, 64'h0, 64'h1, 64'hffff_ffff_ffff_ffff);
    alu_row(7'h00, 3'h1, ENC_RW, 64'h1, 64'h3f, 64'hffff_ffff_8000_0000);
    alu_row(7'h00, 3'h5, ENC_RW, 64'hffff_ffff_8000_0000, 64'h20, 64'hffff_ffff_8000_0000);
    alu_row(7'h00, 3'h5, ENC_RW, 64'h8000_0000, 64'h4, 64'h0800_0000);
    alu_row(7'h20, 3'h5, ENC_RW, 64'h8000_0000, 64'h24, 64'hffff_ffff_f800_0000);
    imm_row(12'h001, 3'h0, ENC_IW, 64'h7fff_ffff, 64'hffff_ffff_8000_0000);
    imm_row(12'hfff, 3'h0, ENC_IW, 64'h0, 64'hffff_ffff_ffff_ffff);
    imm_row(12'h004, 3'h1, ENC_IW, 64'h1800_0000, 64'hffff_ffff_8000_0000);
    imm_row(12'h01f, 3'h5, ENC_IW, 64'hffff_ffff_8000_0000, 64'h1);
    imm_row(12'h41f, 3'h5, ENC_IW, 64'h8000_0000, 64'hffff_ffff_ffff_ffff);

    // m extension
    alu_row(7'h01, 3'h0, ENC_R, 64'hffff_ffff_ffff_fffd, 64'h7, 64'hffff_ffff_ffff_ffeb);
    alu_row(7'h01, 3'h1, ENC_R, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 64'h0);
    alu_row(7'h01, 3'h1, ENC_R, 64'h8000_0000_0000_0000, 64'h2, 64'hffff_ffff_ffff_ffff);
    alu_row(7'h01, 3'h2, ENC_R, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff,
            64'hffff_ffff_ffff_ffff);
    alu_row(7'h01, 3'h2, ENC_R, 64'h2, 64'h8000_0000_0000_0000, 64'h1);
    alu_row(7'h01, 3'h3, ENC_R, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff,
            64'hffff_ffff_ffff_fffe);
    alu_row(7'h01, 3'h4, ENC_R, 64'hffff_ffff_ffff_fff9, 64'h2, 64'hffff_ffff_ffff_fffd);
    alu_row(7'h01, 3'h5, ENC_R, 64'hffff_ffff_ffff_ffff, 64'h2, 64'h7fff_ffff_ffff_ffff);
    alu_row(7'h01, 3'h6, ENC_R, 64'hffff_ffff_ffff_fff9, 64'h2, 64'hffff_ffff_ffff_ffff);
    alu_row(7'h01, 3'h7, ENC_R, 64'hffff_ffff_ffff_ffff, 64'h2, 64'h1);
    // divide by zero: all ones, remainder is the dividend
    alu_row(7'h01, 3'h4, ENC_R, 64'h1234, 64'h0, 64'hffff_ffff_ffff_ffff);
    alu_row(7'h01, 3'h6, ENC_R, 64'h1234, 64'h0, 64'h1234);
    alu_row(7'h01, 3'h5, ENC_R, 64'h5, 64'h0, 64'hffff_ffff_ffff_ffff);
    alu_row(7'h01, 3'h7, ENC_R, 64'hffff_ffff_ffff_fffb, 64'h0, 64'hffff_ffff_ffff_fffb);
    // most negative / -1
    alu_row(7'h01, 3'h4, ENC_R, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff,
            64'h8000_0000_0000_0000);
    alu_row(7'h01, 3'h6, ENC_R, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 64'h0);
    // m word forms
    alu_row(7'h01, 3'h0, ENC_RW, 64'hffff_ffff, 64'h2, 64'hffff_ffff_ffff_fffe);
    alu_row(7'h01, 3'h4, ENC_RW, 64'hffff_ffff_ffff_fff9, 64'h2, 64'hffff_ffff_ffff_fffd);
    alu_row(7'h01, 3'h5, ENC_RW, 64'hffff_fffe, 64'h2, 64'h7fff_ffff);
    alu_row(7'h01, 3'h5, ENC_RW, 64'hffff_fffe, 64'h1, 64'hffff_ffff_ffff_fffe);
    alu_row(7'h01, 3'h6, ENC_RW, 64'hffff_fff9, 64'h2, 64'hffff_ffff_ffff_ffff);
    alu_row(7'h01, 3'h7, ENC_RW, 64'hffff_ffff_8000_0000, 64'h0, 64'hffff_ffff_8000_0000);
    alu_row(7'h01, 3'h4, ENC_RW, 64'h1234, 64'hffff_ffff_0000_0000, 64'hffff_ffff_ffff_ffff);
    alu_row(7'h01, 3'h4, ENC_RW, 64'h8000_0000, 64'hffff_ffff, 64'hffff_ffff_8000_0000);
    alu_row(7'h01, 3'h6, ENC_RW, 64'h8000_0000, 64'hffff_ffff, 64'h0);

    ////////////////////////////////////////////////////////////////////////////
    // loads, stores, illegal and x0
    ////////////////////////////////////////////////////////////////////////////
    mem_row(enc_i(12'h010, 3'h3, ENC_LD, 5'd5), 64'h1000, 64'h1010, 5'd5);
    mem_row(enc_i(12'hff8, 3'h2, ENC_LD, 5'd6), 64'h1000, 64'hff8, 5'd6);
    mem_row(enc_s(12'h7ff, 3'h3), 64'h2000, 64'h27ff, 5'd0);
    mem_row(enc_s(12'hfff, 3'h0), 64'h100, 64'hff, 5'd0);
    illegal_row(enc_r(7'h02, 3'h0, ENC_R, 5'd10));
    illegal_row(enc_r(7'h00, 3'h0, 7'h7f, 5'd10));
    illegal_row(enc_r(7'h00, 3'h2, ENC_RW, 5'd10));
    illegal_row(enc_r(7'h01, 3'h1, ENC_RW, 5'd10));
    illegal_row(enc_i(12'h020, 3'h1, ENC_IW, 5'd10));
    push_vector(enc_r(7'h00, 3'h0, ENC_R, 5'd0), 64'h5, 64'h7, 64'h0, 64'h0, 5'd0, 1'b0, 1'b0);
    push_vector(enc_i(12'h001, 3'h0, ENC_I, 5'd0), 64'h5, 64'h0, 64'h0, 64'h0, 5'd0, 1'b0, 1'b0);
endtask

/* verification/exec_stage_tb.sv */
`default_nettype none

module exec_stage_tb;
    import exec_pkg::*;

    // opcodes as the isa encodes them
    localparam logic [6:0] ENC_R  = 7'h33;
    localparam logic [6:0] ENC_I  = 7'h13;
    localparam logic [6:0] ENC_RW = 7'h3b;
    localparam logic [6:0] ENC_IW = 7'h1b;
    localparam logic [6:0] ENC_LD = 7'h03;
    localparam logic [6:0] ENC_ST = 7'h23;
    localparam int DRAIN_LIMIT = 20;

    typedef struct packed {
        instr_t       instr;
        xlen_t        rs1;
        xlen_t        rs2;
        exec_result_t expected;
    } vector_t;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    instr_t       instr;
    xlen_t        rs1_val;
    xlen_t        rs2_val;
    logic         out_valid;
    exec_result_t out_result;

    vector_t      vectors[$];
    // rows in flight with the oldest first
    int           pending_idx[$];
    int unsigned  pending_cycle[$];
    int unsigned  cycle;
    exec_result_t last_result;
    int           errors;
    int           checks;
    integer       seed;
    int           gap;
    bit           timed_out;

    exec_stage exec_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .instr      (instr),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // encoders and table rows
    ////////////////////////////////////////////////////////////////////////////

    // source registers fixed at x1 and x2
    function automatic instr_t enc_r(input logic [6:0] fn7, input logic [2:0] fn3,
                                     input logic [6:0] opc, input reg_idx_t rd);
        return {fn7, 5'd2, 5'd1, fn3, rd, opc};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input logic [2:0] fn3,
                                     input logic [6:0] opc, input reg_idx_t rd);
        return {imm, 5'd1, fn3, rd, opc};
    endfunction

    function automatic instr_t enc_s(input logic [11:0] imm, input logic [2:0] fn3);
        return {imm[11:5], 5'd2, 5'd1, fn3, imm[4:0], ENC_ST};
    endfunction

    task automatic push_vector(input instr_t ins, input xlen_t a, input xlen_t b,
                               input xlen_t res, input xlen_t addr, input reg_idx_t rd,
                               input logic mem, input logic ill);
        vector_t v;
        v.instr = ins;
        v.rs1 = a;
        v.rs2 = b;
        v.expected.result = res;
        v.expected.mem_addr = addr;
        v.expected.rd = rd;
        v.expected.mem_access = mem;
        v.expected.illegal = ill;
        vectors.push_back(v);
    endtask

    task automatic alu_row(input logic [6:0] fn7, input logic [2:0] fn3, input logic [6:0] opc,
                           input xlen_t a, input xlen_t b, input xlen_t res);
        push_vector(enc_r(fn7, fn3, opc, 5'd10), a, b, res, '0, 5'd10, 1'b0, 1'b0);
    endtask

    // rs2 carries junk so the immediate must win
    task automatic imm_row(input logic [11:0] imm, input logic [2:0] fn3, input logic [6:0] opc,
                           input xlen_t a, input xlen_t res);
        push_vector(enc_i(imm, fn3, opc, 5'd10), a, 64'h5a5a_5a5a_5a5a_5a5a, res, '0,
                    5'd10, 1'b0, 1'b0);
    endtask

    // result is the address unless rd is x0
    task automatic mem_row(input instr_t ins, input xlen_t a, input xlen_t addr,
                           input reg_idx_t rd);
        push_vector(ins, a, 64'h5a5a_5a5a_5a5a_5a5a, (rd == 5'd0) ? '0 : addr, addr, rd,
                    1'b1, 1'b0);
    endtask

    task automatic illegal_row(input instr_t ins);
        push_vector(ins, 64'h5, 64'h7, '0, '0, 5'd0, 1'b0, 1'b1);
    endtask

    `include "exec_stage_vectors.svh"

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and checking
    ////////////////////////////////////////////////////////////////////////////

    // drive one row and leave in_valid high for the caller
    task automatic apply_vector(input int idx);
        instr = vectors[idx].instr;
        rs1_val = vectors[idx].rs1;
        rs2_val = vectors[idx].rs2;
        in_valid = 1'b1;
        pending_idx.push_back(idx);
        pending_cycle.push_back(cycle);
        @(posedge clk);
        #1;
    endtask

    // idle junk writes x11 so any capture without a strobe shows up
    task automatic drive_idle();
        in_valid = 1'b0;
        instr = enc_r(7'h00, 3'h4, ENC_R, 5'd11);
        rs1_val = {$random(seed), $random(seed)};
        rs2_val = {$random(seed), $random(seed)};
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending_idx.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (pending_idx.size() != 0) begin
            $display("timeout: no out_valid for row %0d after %0d cycles",
                     pending_idx[0], DRAIN_LIMIT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_output(input int idx, input int unsigned issued);
        exec_result_t exp;
        exp = vectors[idx].expected;
        checks++;
        if (cycle != issued + 1) begin
            $display("FAILED %0t: row %0d out_valid in cycle %0d, expected %0d",
                     $time, idx, cycle, issued + 1);
            errors++;
        end
        if (out_result.result != exp.result) begin
            $display("FAILED %0t: row %0d result %h, expected %h",
                     $time, idx, out_result.result, exp.result);
            errors++;
        end
        // address only defined for loads and stores
        if (exp.mem_access && out_result.mem_addr != exp.mem_addr) begin
            $display("FAILED %0t: row %0d mem_addr %h, expected %h",
                     $time, idx, out_result.mem_addr, exp.mem_addr);
            errors++;
        end
        if (out_result.rd != exp.rd) begin
            $display("FAILED %0t: row %0d rd %0d, expected %0d",
                     $time, idx, out_result.rd, exp.rd);
            errors++;
        end
        if (out_result.mem_access != exp.mem_access || out_result.illegal != exp.illegal) begin
            $display("FAILED %0t: row %0d mem_access/illegal %b%b, expected %b%b", $time, idx,
                     out_result.mem_access, out_result.illegal, exp.mem_access, exp.illegal);
            errors++;
        end
    endtask

    // sample mid-cycle away from both edges
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                if (pending_idx.size() == 0) begin
                    $display("out_valid at %0t with no instruction in flight", $time);
                    errors++;
                end else begin
                    check_output(pending_idx.pop_front(), pending_cycle.pop_front());
                end
                last_result = out_result;
            end else if (out_result != last_result) begin
                $display("FAILED %0t: out_result changed while out_valid low", $time);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        instr = '0;
        rs1_val = '0;
        rs2_val = '0;
        last_result = '0;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        seed = 90;
        load_vectors();
        repeat (10) @(posedge clk);
        #1;
        if (out_valid !== 1'b0 || out_result !== '0) begin
            $display("FAILED %0t: outputs not cleared by reset", $time);
            errors++;
        end
        rst_n = 1'b1;
        // checker watches these idle cycles for spurious strobes
        repeat (3) @(posedge clk);
        #1;

        // one row at a time
        for (int i = 0; i < vectors.size() && !timed_out; i++) begin
            apply_vector(i);
            drive_idle();
            wait_drain();
        end

        // back to back with random gaps
        if (!timed_out) begin
            for (int i = 0; i < vectors.size(); i++) begin
                apply_vector(i);
                gap = $unsigned($random(seed)) % 3;
                if (gap != 0) begin
                    drive_idle();
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                end
            end
            drive_idle();
            wait_drain();
        end
        repeat (2) @(posedge clk);
        #1;

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv64_exec.f */
+incdir+verification
verilog/exec_pkg.sv
verilog/exec_decoder.sv
verilog/operand_select.sv
verilog/alu.sv
verilog/exec_result_reg.sv
verilog/exec_stage.sv
verification/exec_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= exec_stage_tb
FILELIST  ?= rv64_exec.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
